// ==== verilog/lpif_pkg.sv ====
// lpif link shared definitions with field widths, link word layout and link state encoding
package lpif_pkg;

  //////////////////////////////////////////////////
  // field widths
  //////////////////////////////////////////////////

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int CRC_W    = 16;

  //////////////////////////////////////////////////
  // lsb of each field in the link word
  //////////////////////////////////////////////////

  localparam int STATE_LSB  = 0;
  localparam int PROTID_LSB = 4;
  localparam int DATA_LSB   = 6;
  // single bit flags sit between and above the wide fields
  localparam int DVALID_LSB = 70;
  localparam int CRC_LSB    = 71;
  localparam int CRCV_LSB   = 87;
  localparam int VALID_LSB  = 88;

  // flit valid is the top bit of the word
  localparam int WORD_W = 89;

  //////////////////////////////////////////////////
  // link state as carried in the state field
  //////////////////////////////////////////////////

  typedef enum logic [STATE_W-1:0] {
    LINK_RESET     = 4'h0,
    LINK_ACTIVE    = 4'h1,
    LINK_IDLE      = 4'h2,
    LINK_L1        = 4'h4,
    LINK_L2        = 4'h5,
    LINK_LINKRESET = 4'h9,
    LINK_RETRAIN   = 4'hb,
    LINK_DISABLED  = 4'hc
  } lpif_state_e;

endpackage

// ==== verilog/lpif_tx_striper.sv ====
// lpif transmit striper that packs upstream flit fields and spreads the link word over lanes
`timescale 1ns/1ps

module lpif_tx_striper import lpif_pkg::*; #(
  parameter int LANES = 4,
  parameter int DEPTH = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  lpif_state_e                                ustrm_state,
  input  logic [PROTID_W-1:0]                        ustrm_protid,
  input  logic [DATA_W-1:0]                          ustrm_data,
  input  logic                                       ustrm_dvalid,
  input  logic [CRC_W-1:0]                           ustrm_crc,
  input  logic                                       ustrm_crc_valid,
  input  logic                                       ustrm_valid,
  input  logic                                       ustrm_word_valid,
  output logic                                       ustrm_ready,
  input  logic [LANES-1:0]                           lane_credit,
  output logic [LANES-1:0]                           lane_push,
  output logic [LANES*((WORD_W+LANES-1)/LANES)-1:0]  lane_slice
);

  // slice width per lane with the word padded up to a whole number of slices
  localparam int SLICE_W = (WORD_W + LANES - 1) / LANES;
  localparam int CNT_W   = $clog2(DEPTH + 1);

  logic [LANES*SLICE_W-1:0] link_word;
  logic [CNT_W-1:0]         credit_cnt [LANES];
  logic                     accept;

  //////////////////////////////////////////////////
  // word packing
  //////////////////////////////////////////////////

  always_comb begin
    // pad bits above the flit valid stay zero
    link_word                            = '0;
    link_word[STATE_LSB +: STATE_W]      = ustrm_state;
    link_word[PROTID_LSB +: PROTID_W]    = ustrm_protid;
    link_word[DATA_LSB +: DATA_W]        = ustrm_data;
    link_word[DVALID_LSB]                = ustrm_dvalid;
    link_word[CRC_LSB +: CRC_W]          = ustrm_crc;
    link_word[CRCV_LSB]                  = ustrm_crc_valid;
    link_word[VALID_LSB]                 = ustrm_valid;
  end

  //////////////////////////////////////////////////
  // credit tracking and handshake
  //////////////////////////////////////////////////

  // ready only while every lane still has a free slot
  always_comb begin
    ustrm_ready = 1'b1;
    for (int i = 0; i < LANES; i++) begin
      if (credit_cnt[i] == '0) begin
        ustrm_ready = 1'b0;
      end
    end
  end

  assign accept = ustrm_word_valid && ustrm_ready;

  // counters move on acceptance, not on the registered push,
  // so back to back accepts cannot overrun a lane
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < LANES; i++) begin
        credit_cnt[i] <= CNT_W'(DEPTH);
      end
    end else begin
      for (int i = 0; i < LANES; i++) begin
        case ({accept, lane_credit[i]})
          2'b10:   credit_cnt[i] <= credit_cnt[i] - 1'b1;
          2'b01:   credit_cnt[i] <= credit_cnt[i] + 1'b1;
          // take and return in one cycle cancel out
          default: credit_cnt[i] <= credit_cnt[i];
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // registered lane outputs
  //////////////////////////////////////////////////

  // all lanes are pushed together
  always_ff @(posedge clk) begin
    if (rst) begin
      lane_push <= '0;
    end else begin
      lane_push <= {LANES{accept}};
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lane_slice <= link_word;
    end
  end

endmodule

// ==== verilog/lpif_lane_fifo.sv ====
// lpif lane FIFO that holds one lane's slices and returns a credit for every slot it frees
`timescale 1ns/1ps

module lpif_lane_fifo #(
  parameter int DEPTH   = 4,
  parameter int SLICE_W = 23
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               push,
  input  logic [SLICE_W-1:0] wdata,
  input  logic               pop,
  output logic               avail,
  output logic [SLICE_W-1:0] rdata,
  output logic               credit
);

  // one pointer bit minimum so a single slot FIFO still builds
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [SLICE_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_pop;

  // sender credit guarantees a push never finds the FIFO full
  assign do_pop = pop && avail;
  assign avail  = (count != '0);
  // head slice shown directly
  assign rdata  = mem[rd_ptr];
  // freed slot reported back in the pop cycle
  assign credit = do_pop;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves occupancy unchanged
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/lpif_rx_merger.sv ====
// lpif receive merger that pops all lanes at once, rebuilds the link word and unpacks the fields
`timescale 1ns/1ps

module lpif_rx_merger import lpif_pkg::*; #(
  parameter int LANES = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [LANES-1:0]                           lane_avail,
  input  logic [LANES*((WORD_W+LANES-1)/LANES)-1:0]  lane_rdata,
  output logic [LANES-1:0]                           lane_pop,
  input  logic                                       dstrm_ready,
  output logic                                       dstrm_word_valid,
  output lpif_state_e                                dstrm_state,
  output logic [PROTID_W-1:0]                        dstrm_protid,
  output logic [DATA_W-1:0]                          dstrm_data,
  output logic                                       dstrm_dvalid,
  output logic [CRC_W-1:0]                           dstrm_crc,
  output logic                                       dstrm_crc_valid,
  output logic                                       dstrm_valid
);

  localparam int SLICE_W = (WORD_W + LANES - 1) / LANES;

  logic [LANES*SLICE_W-1:0] link_word;
  logic                     all_avail;
  logic                     out_free;
  logic                     do_pop;

  //////////////////////////////////////////////////
  // pop control
  //////////////////////////////////////////////////

  // lane heads already sit in word order with lane 0 lowest
  assign link_word = lane_rdata;
  assign all_avail = &lane_avail;

  // output register is empty or its word leaves this cycle
  assign out_free  = !dstrm_word_valid || dstrm_ready;
  assign do_pop    = all_avail && out_free;
  assign lane_pop  = {LANES{do_pop}};

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      dstrm_word_valid <= 1'b0;
    end else if (do_pop) begin
      dstrm_word_valid <= 1'b1;
    end else if (dstrm_ready) begin
      dstrm_word_valid <= 1'b0;
    end
  end

  // fields only load on a pop, so they hold while stalled
  always_ff @(posedge clk) begin
    if (do_pop) begin
      dstrm_state     <= lpif_state_e'(link_word[STATE_LSB +: STATE_W]);
      dstrm_protid    <= link_word[PROTID_LSB +: PROTID_W];
      dstrm_data      <= link_word[DATA_LSB +: DATA_W];
      dstrm_dvalid    <= link_word[DVALID_LSB];
      dstrm_crc       <= link_word[CRC_LSB +: CRC_W];
      dstrm_crc_valid <= link_word[CRCV_LSB];
      dstrm_valid     <= link_word[VALID_LSB];
    end
  end

endmodule

// ==== verilog/lpif_link_top.sv ====
// lpif link top with striper, parallel lane FIFOs and merger on a single clock
`timescale 1ns/1ps

module lpif_link_top import lpif_pkg::*; #(
  parameter int LANES = 4,
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  // upstream flit side
  input  lpif_state_e         ustrm_state,
  input  logic [PROTID_W-1:0] ustrm_protid,
  input  logic [DATA_W-1:0]   ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [CRC_W-1:0]    ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,
  input  logic                ustrm_word_valid,
  output logic                ustrm_ready,
  // downstream flit side
  output lpif_state_e         dstrm_state,
  output logic [PROTID_W-1:0] dstrm_protid,
  output logic [DATA_W-1:0]   dstrm_data,
  output logic                dstrm_dvalid,
  output logic [CRC_W-1:0]    dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid,
  output logic                dstrm_word_valid,
  input  logic                dstrm_ready
);

  localparam int SLICE_W = (WORD_W + LANES - 1) / LANES;

  //////////////////////////////////////////////////
  // lane wiring
  //////////////////////////////////////////////////

  logic [LANES-1:0]         lane_push;
  logic [LANES*SLICE_W-1:0] lane_slice;
  logic [LANES-1:0]         lane_credit;
  logic [LANES-1:0]         lane_avail;
  logic [LANES*SLICE_W-1:0] lane_rdata;
  logic [LANES-1:0]         lane_pop;

  lpif_tx_striper #(
    .LANES (LANES),
    .DEPTH (DEPTH)
  ) u_lpif_tx_striper (
    .clk              (clk),
    .rst              (rst),
    .ustrm_state      (ustrm_state),
    .ustrm_protid     (ustrm_protid),
    .ustrm_data       (ustrm_data),
    .ustrm_dvalid     (ustrm_dvalid),
    .ustrm_crc        (ustrm_crc),
    .ustrm_crc_valid  (ustrm_crc_valid),
    .ustrm_valid      (ustrm_valid),
    .ustrm_word_valid (ustrm_word_valid),
    .ustrm_ready      (ustrm_ready),
    .lane_credit      (lane_credit),
    .lane_push        (lane_push),
    .lane_slice       (lane_slice)
  );

  // one FIFO per lane that returns its own credits
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    lpif_lane_fifo #(
      .DEPTH   (DEPTH),
      .SLICE_W (SLICE_W)
    ) u_lpif_lane_fifo (
      .clk    (clk),
      .rst    (rst),
      .push   (lane_push[i]),
      .wdata  (lane_slice[i*SLICE_W +: SLICE_W]),
      .pop    (lane_pop[i]),
      .avail  (lane_avail[i]),
      .rdata  (lane_rdata[i*SLICE_W +: SLICE_W]),
      .credit (lane_credit[i])
    );
  end

  lpif_rx_merger #(
    .LANES (LANES)
  ) u_lpif_rx_merger (
    .clk              (clk),
    .rst              (rst),
    .lane_avail       (lane_avail),
    .lane_rdata       (lane_rdata),
    .lane_pop         (lane_pop),
    .dstrm_ready      (dstrm_ready),
    .dstrm_word_valid (dstrm_word_valid),
    .dstrm_state      (dstrm_state),
    .dstrm_protid     (dstrm_protid),
    .dstrm_data       (dstrm_data),
    .dstrm_dvalid     (dstrm_dvalid),
    .dstrm_crc        (dstrm_crc),
    .dstrm_crc_valid  (dstrm_crc_valid),
    .dstrm_valid      (dstrm_valid)
  );

endmodule

// ==== sim/lpif_link_tb.sv ====
// lpif link testbench that sends random flits through the striped link against a reference queue
`timescale 1ns/1ps

module lpif_link_tb import lpif_pkg::*; ();

  localparam int LANES      = 4;
  localparam int DEPTH      = 4;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 4;
  // cycles from the accept cycle to the first cycle with dstrm_word_valid high
  localparam int LAT        = 3;
  localparam int N_SINGLE   = 8;
  localparam int STREAM_N   = 300;
  localparam int BP_CYCLES  = 12;
  localparam int MIX_CYCLES = 500;
  localparam int DRAIN_MAX  = 20;
  localparam int TOTAL_CYCLES = RST_CYCLES + N_SINGLE * (LAT + 1) + STREAM_N + BP_CYCLES
                                + MIX_CYCLES + 4 * DRAIN_MAX;
  localparam int TIMEOUT_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD;

  // one flit as seen on either user side
  typedef struct packed {
    lpif_state_e         state;
    logic [PROTID_W-1:0] protid;
    logic [DATA_W-1:0]   data;
    logic                dvalid;
    logic [CRC_W-1:0]    crc;
    logic                crc_valid;
    logic                valid;
  } flit_t;

  logic                clk;
  logic                rst;
  lpif_state_e         ustrm_state;
  logic [PROTID_W-1:0] ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic                ustrm_dvalid;
  logic [CRC_W-1:0]    ustrm_crc;
  logic                ustrm_crc_valid;
  logic                ustrm_valid;
  logic                ustrm_word_valid;
  logic                ustrm_ready;
  lpif_state_e         dstrm_state;
  logic [PROTID_W-1:0] dstrm_protid;
  logic [DATA_W-1:0]   dstrm_data;
  logic                dstrm_dvalid;
  logic [CRC_W-1:0]    dstrm_crc;
  logic                dstrm_crc_valid;
  logic                dstrm_valid;
  logic                dstrm_word_valid;
  logic                dstrm_ready;

  integer seed = 70;
  // reference model of flits accepted upstream and not yet delivered
  flit_t  model_q [$];
  lpif_state_e state_pool [8] = '{LINK_RESET, LINK_ACTIVE, LINK_IDLE, LINK_RETRAIN,
                                  LINK_L1, LINK_L2, LINK_LINKRESET, LINK_DISABLED};

  lpif_link_top #(
    .LANES (LANES),
    .DEPTH (DEPTH)
  ) u_lpif_link_top (
    .clk              (clk),
    .rst              (rst),
    .ustrm_state      (ustrm_state),
    .ustrm_protid     (ustrm_protid),
    .ustrm_data       (ustrm_data),
    .ustrm_dvalid     (ustrm_dvalid),
    .ustrm_crc        (ustrm_crc),
    .ustrm_crc_valid  (ustrm_crc_valid),
    .ustrm_valid      (ustrm_valid),
    .ustrm_word_valid (ustrm_word_valid),
    .ustrm_ready      (ustrm_ready),
    .dstrm_state      (dstrm_state),
    .dstrm_protid     (dstrm_protid),
    .dstrm_data       (dstrm_data),
    .dstrm_dvalid     (dstrm_dvalid),
    .dstrm_crc        (dstrm_crc),
    .dstrm_crc_valid  (dstrm_crc_valid),
    .dstrm_valid      (dstrm_valid),
    .dstrm_word_valid (dstrm_word_valid),
    .dstrm_ready      (dstrm_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // failure reporting and comparison
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      abort_run($sformatf("ERR %0t: %s expected %0h got %0h", $time, what, exp_val, act_val));
    end
  endtask

  task automatic compare_flit(input string what, input flit_t exp_f, input flit_t act_f);
    check_value({what, " state"}, exp_f.state, act_f.state);
    check_value({what, " protid"}, exp_f.protid, act_f.protid);
    check_value({what, " data"}, exp_f.data, act_f.data);
    check_value({what, " dvalid"}, exp_f.dvalid, act_f.dvalid);
    check_value({what, " crc"}, exp_f.crc, act_f.crc);
    check_value({what, " crc_valid"}, exp_f.crc_valid, act_f.crc_valid);
    check_value({what, " valid"}, exp_f.valid, act_f.valid);
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // state drawn only from legal encodings
  function automatic flit_t random_flit();
    flit_t f;
    f.state     = state_pool[{$random(seed)} % 8];
    f.protid    = PROTID_W'($random(seed));
    f.data      = {$random(seed), $random(seed)};
    f.dvalid    = 1'($random(seed));
    f.crc       = CRC_W'($random(seed));
    f.crc_valid = 1'($random(seed));
    f.valid     = 1'($random(seed));
    return f;
  endfunction

  function automatic flit_t output_flit();
    flit_t f;
    f.state     = dstrm_state;
    f.protid    = dstrm_protid;
    f.data      = dstrm_data;
    f.dvalid    = dstrm_dvalid;
    f.crc       = dstrm_crc;
    f.crc_valid = dstrm_crc_valid;
    f.valid     = dstrm_valid;
    return f;
  endfunction

  // one clock cycle that drives at the falling edge and scores the next rising edge
  task automatic run_cycle(input flit_t f, input bit offer, input bit take_en,
                           output bit acc, output bit tk);
    @(negedge clk);
    ustrm_state      = f.state;
    ustrm_protid     = f.protid;
    ustrm_data       = f.data;
    ustrm_dvalid     = f.dvalid;
    ustrm_crc        = f.crc;
    ustrm_crc_valid  = f.crc_valid;
    ustrm_valid      = f.valid;
    ustrm_word_valid = offer;
    dstrm_ready      = take_en;
    // DUT outputs only move on the rising edge, so they are settled here
    acc = ustrm_word_valid && ustrm_ready;
    tk  = dstrm_word_valid && dstrm_ready;
    if (tk) begin
      if (model_q.size() == 0) begin
        abort_run("downstream delivered a flit that was never accepted upstream");
      end
      compare_flit("downstream", model_q.pop_front(), output_flit());
    end
    if (acc) begin
      model_q.push_back(f);
    end
  endtask

  // upstream idle and downstream ready until the model has nothing left
  task automatic drain_link;
    bit acc;
    bit tk;
    int n_cyc;
    n_cyc = 0;
    while (model_q.size() != 0 && n_cyc < DRAIN_MAX) begin
      run_cycle(random_flit(), 1'b0, 1'b1, acc, tk);
      n_cyc++;
    end
    check_value("flits still missing after drain", 0, model_q.size());
    // a few quiet cycles catch a flit delivered twice
    repeat (LAT) begin
      run_cycle(random_flit(), 1'b0, 1'b1, acc, tk);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    bit    acc;
    bit    tk;
    bit    offer_r;
    bit    ready_r;
    bit    held_ok;
    int    n_acc;
    flit_t f;
    clk              = 1'b0;
    rst              = 1'b1;
    ustrm_state      = LINK_RESET;
    ustrm_protid     = '0;
    ustrm_data       = '0;
    ustrm_dvalid     = 1'b0;
    ustrm_crc        = '0;
    ustrm_crc_valid  = 1'b0;
    ustrm_valid      = 1'b0;
    ustrm_word_valid = 1'b0;
    dstrm_ready      = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_value("word valid after reset", 0, dstrm_word_valid);
    check_value("ready after reset", 1, ustrm_ready);

    // single flits through an empty link with the data edge cases first
    for (int i = 0; i < N_SINGLE; i++) begin
      f = random_flit();
      if (i == 0) f.data = '1;
      if (i == 1) f.data = '0;
      run_cycle(f, 1'b1, 1'b1, acc, tk);
      check_value("single accept", 1, acc);
      for (int k = 1; k <= LAT; k++) begin
        run_cycle(random_flit(), 1'b0, 1'b1, acc, tk);
        check_value("single latency valid", (k == LAT), tk);
      end
    end

    // full rate stream with an output every cycle once the pipe is primed
    for (int i = 0; i < STREAM_N; i++) begin
      run_cycle(random_flit(), 1'b1, 1'b1, acc, tk);
      check_value("stream accept", 1, acc);
      if (i >= LAT) check_value("stream output rate", 1, tk);
    end
    drain_link;

    // downstream stalled so the output register and then the lane FIFOs fill up
    n_acc   = 0;
    held_ok = 1'b0;
    for (int i = 0; i < BP_CYCLES; i++) begin
      run_cycle(random_flit(), 1'b1, 1'b0, acc, tk);
      n_acc += acc;
      if (held_ok) begin
        check_value("held word valid", 1, dstrm_word_valid);
      end
      // stalled output stays on the oldest accepted flit
      if (dstrm_word_valid && model_q.size() != 0) begin
        compare_flit("held output", model_q[0], output_flit());
        held_ok = 1'b1;
      end
    end
    check_value("flits accepted under back-pressure", DEPTH + 1, n_acc);
    check_value("ready with credits exhausted", 0, ustrm_ready);

    // credits come back as the lanes empty once downstream is released
    drain_link;
    check_value("ready after credit return", 1, ustrm_ready);

    // random offer and random back-pressure
    for (int i = 0; i < MIX_CYCLES; i++) begin
      offer_r = 1'($random(seed));
      ready_r = 1'($random(seed));
      run_cycle(random_flit(), offer_r, ready_r, acc, tk);
    end
    drain_link;
    check_value("ready at end", 1, ustrm_ready);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // watchdog sized from the phase lengths
  initial begin
    #(TIMEOUT_NS);
    abort_run("timeout: the link stopped moving flits before all test phases finished");
  end

endmodule

// ==== lpif_link.f ====
verilog/lpif_pkg.sv
verilog/lpif_tx_striper.sv
verilog/lpif_lane_fifo.sv
verilog/lpif_rx_merger.sv
verilog/lpif_link_top.sv
sim/lpif_link_tb.sv

// ==== Bender.yml ====
package:
  name: lpif_link

sources:
  # shared package first, then the link blocks bottom up
  - verilog/lpif_pkg.sv
  - verilog/lpif_tx_striper.sv
  - verilog/lpif_lane_fifo.sv
  - verilog/lpif_rx_merger.sv
  - verilog/lpif_link_top.sv

  - target: simulation
    files:
      - sim/lpif_link_tb.sv
